// File: design/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// line and flag levels
`define LOW  1'b0
`define HIGH 1'b1

// core bus widths
`define ADDR_BIT 32
`define DATA_BIT 32

// register window of the controller
`define UART_BASE 32'h2000_0000

// register offsets inside the window
`define REG_CTRL   4'h0
`define REG_STAT   4'h4
`define REG_RXDATA 4'h8
`define REG_TXDATA 4'hC

// entries in each of the two FIFOs
`define FIFO_DEPTH 8

// cycles per bit after reset
`define DIV_RESET 16'd16

`endif

// File: design/uart_pkg.sv
package uart_pkg;

    // register picked by the address decoder
    typedef enum logic [2:0] {
        SEL_CTRL,
        SEL_STAT,
        SEL_RXDATA,
        SEL_TXDATA,
        SEL_NONE
    } reg_sel_e;

    // transmitter frame states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    // receiver frame states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

// File: design/uart_fifo.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] pop_data_o,
    output logic             empty_o,
    output logic             full_o
);

    localparam int PTR_BIT = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BIT = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]   mem_q [DEPTH];
    logic [PTR_BIT-1:0] wr_ptr_q;
    logic [PTR_BIT-1:0] rd_ptr_q;
    logic [CNT_BIT-1:0] count_q;
    logic               do_push;
    logic               do_pop;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_BIT-1:0] next_ptr(input logic [PTR_BIT-1:0] ptr);
        if (ptr == PTR_BIT'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push    = push_i && !full_o;
    assign do_pop     = pop_i && !empty_o;
    assign empty_o    = (count_q == '0);
    assign full_o     = (count_q == CNT_BIT'(DEPTH));
    // head entry, visible before the pop
    assign pop_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_tx (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        enable_i,
    input  logic [15:0] divisor_i,
    input  logic        fifo_empty_i,
    input  logic [7:0]  fifo_data_i,
    output logic        fifo_pop_o,
    output logic        tx_o,
    output logic        busy_o
);

    import uart_pkg::*;

    tx_state_e   state_q;
    logic [15:0] cnt_q;
    logic [2:0]  bit_q;
    logic [7:0]  shift_q;
    logic        tx_q;
    logic        bit_done;
    logic        start;

    // last cycle of a bit period, a zero divisor acts as one
    assign bit_done   = ({1'b0, cnt_q} + 17'd1) >= {1'b0, divisor_i};
    assign start      = (state_q == TX_IDLE) && enable_i && !fifo_empty_i;
    assign fifo_pop_o = start;
    assign busy_o     = (state_q != TX_IDLE);
    assign tx_o       = tx_q;

    // byte being shifted out, lsb on the line
    always_ff @(posedge clk_i) begin
        if (start) begin
            shift_q <= fifo_data_i;
        end else if (state_q == TX_DATA && bit_done) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= TX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            tx_q    <= `HIGH;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    cnt_q <= '0;
                    if (start) begin
                        state_q <= TX_START;
                        tx_q    <= `LOW;
                    end
                end
                TX_START: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (bit_done) begin
                        state_q <= TX_DATA;
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        tx_q    <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (bit_done) begin
                        cnt_q <= '0;
                        bit_q <= bit_q + 1'b1;
                        tx_q  <= shift_q[1];
                        if (bit_q == 3'd7) begin
                            state_q <= TX_STOP;
                            tx_q    <= `HIGH;
                        end
                    end
                end
                TX_STOP: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (bit_done) begin
                        state_q <= TX_IDLE;
                        cnt_q   <= '0;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

endmodule

// File: design/uart_rx.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_rx (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        enable_i,
    input  logic [15:0] divisor_i,
    input  logic        rx_i,
    input  logic        fifo_full_i,
    output logic        fifo_push_o,
    output logic [7:0]  fifo_data_o
);

    import uart_pkg::*;

    rx_state_e   state_q;
    logic        rx_s1_q;
    logic        rx_s2_q;
    logic        rx_d_q;
    logic [15:0] cnt_q;
    logic [2:0]  bit_q;
    logic [7:0]  shift_q;
    logic        fall;
    logic        half_done;
    logic        bit_done;

    assign fall      = rx_d_q && !rx_s2_q;
    assign half_done = ({1'b0, cnt_q} + 17'd1) >= {2'b00, divisor_i[15:1]};
    assign bit_done  = ({1'b0, cnt_q} + 17'd1) >= {1'b0, divisor_i};

    // stop sample taken here, byte lands in the FIFO on this edge
    assign fifo_push_o = (state_q == RX_STOP) && bit_done && (rx_s2_q == `HIGH) && !fifo_full_i;
    assign fifo_data_o = shift_q;

    // two flop synchronizer plus one for edge detection
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rx_s1_q <= `HIGH;
            rx_s2_q <= `HIGH;
            rx_d_q  <= `HIGH;
        end else begin
            rx_s1_q <= rx_i;
            rx_s2_q <= rx_s1_q;
            rx_d_q  <= rx_s2_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && bit_done) begin
            shift_q <= {rx_s2_q, shift_q[7:1]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= RX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
        end else begin
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (enable_i && fall) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    cnt_q <= cnt_q + 1'b1;
                    // middle of start bit, a high level was a glitch
                    if (half_done) begin
                        cnt_q <= '0;
                        bit_q <= '0;
                        if (rx_s2_q == `LOW) begin
                            state_q <= RX_DATA;
                        end else begin
                            state_q <= RX_IDLE;
                        end
                    end
                end
                RX_DATA: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (bit_done) begin
                        cnt_q <= '0;
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (bit_done) begin
                        cnt_q   <= '0;
                        state_q <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

endmodule

// File: design/uart_regs.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_regs (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic [`ADDR_BIT-1:0] core_addr_i,
    input  logic [`DATA_BIT-1:0] core_wdata_i,
    input  logic                 core_write_i,
    input  logic                 core_valid_i,
    output logic                 core_ready_o,
    output logic [`DATA_BIT-1:0] uart_data_o,
    output logic                 uart_valid_o,
    input  logic                 uart_ready_i,
    output logic                 tx_enable_o,
    output logic                 rx_enable_o,
    output logic [15:0]          divisor_o,
    output logic                 tx_push_o,
    output logic [7:0]           tx_push_data_o,
    input  logic                 tx_empty_i,
    input  logic                 tx_full_i,
    output logic                 rx_pop_o,
    input  logic [7:0]           rx_data_i,
    input  logic                 rx_empty_i,
    input  logic                 rx_full_i,
    input  logic                 tx_busy_i
);

    import uart_pkg::*;

    // low address bits that select inside the window
    localparam int WIN_BIT = 16;
    localparam logic [`ADDR_BIT-1:0] BASE = `UART_BASE;

    reg_sel_e             sel;
    logic                 accept;
    logic                 rd_acc;
    logic                 wr_acc;
    logic                 tx_en_q;
    logic                 rx_en_q;
    logic [15:0]          div_q;
    logic [`DATA_BIT-1:0] status;
    logic [`DATA_BIT-1:0] rdata;
    logic                 resp_valid_q;
    logic [`DATA_BIT-1:0] resp_data_q;

    always_comb begin
        sel = SEL_NONE;
        if (core_addr_i[`ADDR_BIT-1:WIN_BIT] == BASE[`ADDR_BIT-1:WIN_BIT]) begin
            case (core_addr_i[WIN_BIT-1:0])
                `REG_CTRL:   sel = SEL_CTRL;
                `REG_STAT:   sel = SEL_STAT;
                `REG_RXDATA: sel = SEL_RXDATA;
                `REG_TXDATA: sel = SEL_TXDATA;
                default:     sel = SEL_NONE;
            endcase
        end
    end

    // no new request while a read response waits
    assign core_ready_o = !resp_valid_q;
    assign accept       = core_valid_i && core_ready_o;
    assign rd_acc       = accept && !core_write_i;
    assign wr_acc       = accept && core_write_i;

    // full FIFO drops the write, empty FIFO is never popped
    assign tx_push_o      = wr_acc && (sel == SEL_TXDATA) && !tx_full_i;
    assign tx_push_data_o = core_wdata_i[7:0];
    assign rx_pop_o       = rd_acc && (sel == SEL_RXDATA) && !rx_empty_i;

    assign status = {{(`DATA_BIT-5){1'b0}}, tx_busy_i, rx_full_i, !rx_empty_i,
                     tx_full_i, tx_empty_i};

    always_comb begin
        case (sel)
            SEL_CTRL:   rdata = {div_q, 14'd0, rx_en_q, tx_en_q};
            SEL_STAT:   rdata = status;
            SEL_RXDATA: rdata = rx_empty_i ? '0 : {{(`DATA_BIT-8){1'b0}}, rx_data_i};
            default:    rdata = '0;
        endcase
    end

    // control register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tx_en_q <= `LOW;
            rx_en_q <= `LOW;
            div_q   <= `DIV_RESET;
        end else if (wr_acc && sel == SEL_CTRL) begin
            tx_en_q <= core_wdata_i[0];
            rx_en_q <= core_wdata_i[1];
            div_q   <= core_wdata_i[31:16];
        end
    end

    assign tx_enable_o = tx_en_q;
    assign rx_enable_o = rx_en_q;
    assign divisor_o   = div_q;

    // read response, held until taken
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            resp_valid_q <= `LOW;
        end else if (rd_acc) begin
            resp_valid_q <= `HIGH;
        end else if (resp_valid_q && uart_ready_i) begin
            resp_valid_q <= `LOW;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_acc) begin
            resp_data_q <= rdata;
        end
    end

    assign uart_valid_o = resp_valid_q;
    assign uart_data_o  = resp_data_q;

endmodule

// File: design/uart_controller.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_controller (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic [`ADDR_BIT-1:0] core_addr_i,
    input  logic [`DATA_BIT-1:0] core_wdata_i,
    input  logic                 core_write_i,
    input  logic                 core_valid_i,
    output logic                 core_ready_o,
    output logic [`DATA_BIT-1:0] uart_data_o,
    output logic                 uart_valid_o,
    input  logic                 uart_ready_i,
    input  logic                 rx_i,
    output logic                 tx_o
);

    logic        tx_enable;
    logic        rx_enable;
    logic [15:0] divisor;
    logic        tx_push;
    logic [7:0]  tx_push_data;
    logic        tx_pop;
    logic [7:0]  tx_pop_data;
    logic        tx_empty;
    logic        tx_full;
    logic        tx_busy;
    logic        rx_push;
    logic [7:0]  rx_push_data;
    logic        rx_pop;
    logic [7:0]  rx_pop_data;
    logic        rx_empty;
    logic        rx_full;

    uart_regs i_regs (
        .clk_i          ( clk_i ),
        .reset_i        ( reset_i ),
        .core_addr_i    ( core_addr_i ),
        .core_wdata_i   ( core_wdata_i ),
        .core_write_i   ( core_write_i ),
        .core_valid_i   ( core_valid_i ),
        .core_ready_o   ( core_ready_o ),
        .uart_data_o    ( uart_data_o ),
        .uart_valid_o   ( uart_valid_o ),
        .uart_ready_i   ( uart_ready_i ),
        .tx_enable_o    ( tx_enable ),
        .rx_enable_o    ( rx_enable ),
        .divisor_o      ( divisor ),
        .tx_push_o      ( tx_push ),
        .tx_push_data_o ( tx_push_data ),
        .tx_empty_i     ( tx_empty ),
        .tx_full_i      ( tx_full ),
        .rx_pop_o       ( rx_pop ),
        .rx_data_i      ( rx_pop_data ),
        .rx_empty_i     ( rx_empty ),
        .rx_full_i      ( rx_full ),
        .tx_busy_i      ( tx_busy )
    );

    // transmit side
    uart_fifo #(.WIDTH(8), .DEPTH(`FIFO_DEPTH)) i_tx_fifo (
        .clk_i       ( clk_i ),
        .reset_i     ( reset_i ),
        .push_i      ( tx_push ),
        .push_data_i ( tx_push_data ),
        .pop_i       ( tx_pop ),
        .pop_data_o  ( tx_pop_data ),
        .empty_o     ( tx_empty ),
        .full_o      ( tx_full )
    );

    uart_tx i_tx (
        .clk_i        ( clk_i ),
        .reset_i      ( reset_i ),
        .enable_i     ( tx_enable ),
        .divisor_i    ( divisor ),
        .fifo_empty_i ( tx_empty ),
        .fifo_data_i  ( tx_pop_data ),
        .fifo_pop_o   ( tx_pop ),
        .tx_o         ( tx_o ),
        .busy_o       ( tx_busy )
    );

    // receive side
    uart_fifo #(.WIDTH(8), .DEPTH(`FIFO_DEPTH)) i_rx_fifo (
        .clk_i       ( clk_i ),
        .reset_i     ( reset_i ),
        .push_i      ( rx_push ),
        .push_data_i ( rx_push_data ),
        .pop_i       ( rx_pop ),
        .pop_data_o  ( rx_pop_data ),
        .empty_o     ( rx_empty ),
        .full_o      ( rx_full )
    );

    uart_rx i_rx (
        .clk_i       ( clk_i ),
        .reset_i     ( reset_i ),
        .enable_i    ( rx_enable ),
        .divisor_i   ( divisor ),
        .rx_i        ( rx_i ),
        .fifo_full_i ( rx_full ),
        .fifo_push_o ( rx_push ),
        .fifo_data_o ( rx_push_data )
    );

endmodule

// File: verification/tb_uart_controller.sv
`timescale 1ns/1ps

`include "uart_defines.svh"

module tb_uart_controller;

    import uart_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int TEST_DIV    = 8;
    // 20 transmitted, 6 received, 3 in the rule checks
    localparam int FRAME_COUNT = 29;
    localparam int WATCHDOG_NS = 2 * FRAME_COUNT * 10 * TEST_DIV * CLK_PERIOD + 200_000;

    localparam logic [31:0] BASE_ADDR   = `UART_BASE;
    localparam logic [31:0] CTRL_ADDR   = BASE_ADDR + `REG_CTRL;
    localparam logic [31:0] STAT_ADDR   = BASE_ADDR + `REG_STAT;
    localparam logic [31:0] RXDATA_ADDR = BASE_ADDR + `REG_RXDATA;
    localparam logic [31:0] TXDATA_ADDR = BASE_ADDR + `REG_TXDATA;

    logic                 clk = 1'b0;
    logic                 reset;
    logic [`ADDR_BIT-1:0] core_addr;
    logic [`DATA_BIT-1:0] core_wdata;
    logic                 core_write;
    logic                 core_valid;
    logic                 core_ready;
    logic [`DATA_BIT-1:0] uart_data;
    logic                 uart_valid;
    logic                 uart_ready;
    logic                 rx;
    logic                 tx;

    int         errors = 0;
    int         checks = 0;
    int         bit_cycles;
    logic [7:0] exp_tx[$];
    logic [7:0] exp_rx[$];
    logic [9:0] mon_frames[$];
    logic [9:0] mon_line;
    event       frame_seen;

    uart_controller i_dut (
        .clk_i        ( clk ),
        .reset_i      ( reset ),
        .core_addr_i  ( core_addr ),
        .core_wdata_i ( core_wdata ),
        .core_write_i ( core_write ),
        .core_valid_i ( core_valid ),
        .core_ready_o ( core_ready ),
        .uart_data_o  ( uart_data ),
        .uart_valid_o ( uart_valid ),
        .uart_ready_i ( uart_ready ),
        .rx_i         ( rx ),
        .tx_o         ( tx )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // line sequence from start bit to stop bit with data lsb first
    function automatic logic [9:0] frame_bits(input logic [7:0] data);
        logic [9:0] line;
        line[0] = 1'b0;
        for (int i = 0; i < 8; i++) begin
            line[i + 1] = data[i];
        end
        line[9] = 1'b1;
        return line;
    endfunction

    function automatic logic [31:0] ctrl_word(input logic [15:0] div, input logic rx_en,
                                              input logic tx_en);
        return {div, 14'd0, rx_en, tx_en};
    endfunction

    function automatic reg_sel_e decode_offset(input logic [31:0] addr);
        if (addr[31:16] != BASE_ADDR[31:16]) begin
            return SEL_NONE;
        end
        case (addr[15:0])
            {12'd0, `REG_CTRL}:   return SEL_CTRL;
            {12'd0, `REG_STAT}:   return SEL_STAT;
            {12'd0, `REG_RXDATA}: return SEL_RXDATA;
            {12'd0, `REG_TXDATA}: return SEL_TXDATA;
            default:              return SEL_NONE;
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic log_failure(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // returns right after the edge that takes the request
    task automatic wait_accept();
        @(negedge clk);
        while (!core_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        core_addr  <= addr;
        core_wdata <= data;
        core_write <= 1'b1;
        core_valid <= 1'b1;
        wait_accept();
        core_valid <= 1'b0;
        core_write <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, input int hold, output logic [31:0] data);
        @(posedge clk);
        core_addr  <= addr;
        core_write <= 1'b0;
        core_valid <= 1'b1;
        wait_accept();
        core_valid <= 1'b0;
        @(negedge clk);
        checks++;
        if (uart_valid !== 1'b1) begin
            log_failure("no read response one cycle after the read was accepted");
        end
        data = uart_data;
        // response must hold while ready stays low
        for (int i = 0; i <= hold; i++) begin
            if (i == hold) begin
                @(posedge clk);
                uart_ready <= 1'b1;
                @(negedge clk);
            end else begin
                @(posedge clk);
                @(negedge clk);
            end
            checks++;
            if (uart_data !== data) begin
                report_mismatch("held read data", uart_data, data);
            end
            if (uart_valid !== 1'b1 || core_ready !== 1'b0) begin
                log_failure("response dropped or core_ready_o high before it was taken");
            end
        end
        @(posedge clk);
        uart_ready <= 1'b0;
        @(negedge clk);
        checks++;
        if (uart_valid !== 1'b0 || core_ready !== 1'b1) begin
            log_failure("response still pending after uart_ready_i was high");
        end
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        reg_sel_e    sel;
        sel = decode_offset(addr);
        bus_read(addr, $urandom_range(4, 0), data);
        checks++;
        if (data !== exp) begin
            report_mismatch(sel.name(), data, exp);
        end
    endtask

    // serial driver on rx with a selectable stop level for the bad frame case
    task automatic send_frame(input logic [7:0] data, input logic stop_level);
        logic [9:0] line;
        line    = frame_bits(data);
        line[9] = stop_level;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= line[i];
            repeat (bit_cycles - 1) @(posedge clk);
        end
        @(posedge clk);
        rx <= 1'b1;
        // idle gap so the receiver has taken its stop sample
        repeat (bit_cycles) @(posedge clk);
    endtask

    // tx monitor sampling each bit near its middle
    always begin
        @(negedge tx);
        repeat (bit_cycles / 2) @(negedge clk);
        mon_line[0] = tx;
        for (int i = 1; i < 10; i++) begin
            repeat (bit_cycles) @(negedge clk);
            mon_line[i] = tx;
        end
        mon_frames.push_back(mon_line);
        -> frame_seen;
    end

    // compare monitored frames against the expected bytes in order
    always begin
        logic [9:0] frame;
        logic [7:0] exp_byte;
        @(frame_seen);
        while (mon_frames.size() > 0) begin
            frame = mon_frames.pop_front();
            checks++;
            if (exp_tx.size() == 0) begin
                log_failure($sformatf("unexpected frame with byte %h on tx_o", frame[8:1]));
            end else begin
                exp_byte = exp_tx.pop_front();
                if (frame !== frame_bits(exp_byte)) begin
                    report_mismatch("tx_o frame", {22'd0, frame}, {22'd0, frame_bits(exp_byte)});
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin : main_seq
        logic [31:0] data;
        logic [7:0]  value;
        int unsigned seed_val;
        seed_val   = $urandom(65);
        reset      = 1'b1;
        core_addr  = '0;
        core_wdata = '0;
        core_write = 1'b0;
        core_valid = 1'b0;
        uart_ready = 1'b0;
        rx         = 1'b1;
        bit_cycles = `DIV_RESET;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // state after reset
        checks++;
        if (tx !== 1'b1 || core_ready !== 1'b1 || uart_valid !== 1'b0) begin
            log_failure("tx_o, core_ready_o or uart_valid_o wrong after reset");
        end
        read_expect(CTRL_ADDR, ctrl_word(`DIV_RESET, 1'b0, 1'b0));
        read_expect(STAT_ADDR, 32'h1);

        // transmit while stalling on a full tx FIFO
        bus_write(CTRL_ADDR, ctrl_word(TEST_DIV, 1'b0, 1'b1));
        bit_cycles = TEST_DIV;
        for (int n = 0; n < 20; n++) begin
            bus_read(STAT_ADDR, $urandom_range(4, 0), data);
            while (data[1]) begin
                bus_read(STAT_ADDR, $urandom_range(4, 0), data);
            end
            value = 8'($urandom());
            exp_tx.push_back(value);
            bus_write(TXDATA_ADDR, {24'd0, value});
        end
        while (exp_tx.size() != 0) begin
            @(posedge clk);
        end
        // rest of the last stop bit
        repeat (bit_cycles) @(posedge clk);
        read_expect(STAT_ADDR, 32'h1);

        // receive
        bus_write(CTRL_ADDR, ctrl_word(TEST_DIV, 1'b1, 1'b0));
        for (int n = 0; n < 6; n++) begin
            value = 8'($urandom());
            exp_rx.push_back(value);
            send_frame(value, 1'b1);
        end
        read_expect(STAT_ADDR, 32'h5);
        while (exp_rx.size() != 0) begin
            read_expect(RXDATA_ADDR, {24'd0, exp_rx.pop_front()});
        end
        read_expect(RXDATA_ADDR, 32'h0);
        read_expect(STAT_ADDR, 32'h1);

        // frame with rx disabled is not stored
        bus_write(CTRL_ADDR, ctrl_word(TEST_DIV, 1'b0, 1'b0));
        send_frame(8'($urandom()), 1'b1);
        read_expect(STAT_ADDR, 32'h1);
        read_expect(RXDATA_ADDR, 32'h0);

        // low stop bit drops the frame and the next good one is kept
        bus_write(CTRL_ADDR, ctrl_word(TEST_DIV, 1'b1, 1'b0));
        send_frame(8'($urandom()), 1'b0);
        read_expect(STAT_ADDR, 32'h1);
        value = 8'($urandom());
        send_frame(value, 1'b1);
        read_expect(STAT_ADDR, 32'h5);
        read_expect(RXDATA_ADDR, {24'd0, value});
        read_expect(STAT_ADDR, 32'h1);

        // unmapped offsets inside the window
        read_expect(BASE_ADDR + 32'h10, 32'h0);
        read_expect(BASE_ADDR + 32'h100, 32'h0);
        read_expect(BASE_ADDR + 32'hFFFC, 32'h0);
        bus_write(BASE_ADDR + 32'h10, 32'hFFFF_FFFF);
        bus_write(BASE_ADDR + 32'h100, 32'hFFFF_FFFF);
        read_expect(CTRL_ADDR, ctrl_word(TEST_DIV, 1'b1, 1'b0));
        read_expect(STAT_ADDR, 32'h1);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+design
design/uart_pkg.sv
design/uart_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart_controller.sv
verification/tb_uart_controller.sv

// File: Makefile
TOP = tb_uart_controller

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
